// ==== design/bb_params.svh ====
`ifndef BB_PARAMS_SVH
`define BB_PARAMS_SVH

// clk_6M cycles per 1 us bit period
`define BB_CYC_PER_US 6

// clk_6M cycles per 312.5 us half-slot
`define BB_CYC_PER_HSLOT 1875

// native and piconet clock width
`define BB_CLK_W 28

`define BB_SYNC_W 64
`define BB_LAP_W 24

// match count and threshold, 0 to 64
`define BB_CORR_W 7

// scan interval and window, in slots
`define BB_SCAN_W 16

`endif

// ==== design/bb_pkg.sv ====
`default_nettype none

`include "bb_params.svh"

package bb_pkg;

  typedef enum logic [1:0] {
    standby      = 2'd0,
    page_scan    = 2'd1,
    inquiry_scan = 2'd2,
    connection   = 2'd3
  } link_state_e;

  // slot number plus half-slot phase
  typedef struct packed {
    logic [`BB_CLK_W-3:0] slot;
    logic [1:0]           phase;
  } bt_clock_fields_t;

  typedef union packed {
    logic [`BB_CLK_W-1:0] raw;
    bt_clock_fields_t     fld;
  } bt_clock_u;

  typedef struct packed {
    logic [7:0]           uap;
    logic [`BB_LAP_W-1:0] lap;
  } bd_addr_t;

  // address word for the hop kernel
  typedef struct packed {
    logic [3:0]           uap_lo;
    logic [`BB_LAP_W-1:0] lap;
  } hop_addr_t;

  typedef struct packed {
    logic [`BB_SCAN_W-1:0] interval;
    logic [`BB_SCAN_W-1:0] window;
  } scan_cfg_t;

endpackage

`default_nettype wire

// ==== design/bb_timebase.sv ====
`default_nettype none

`include "bb_params.svh"

module bb_timebase (
  input  logic                 clk_6M,
  input  logic                 rstz,
  input  logic                 is_master,
  input  logic [`BB_CLK_W-1:0] clk_offset,
  output logic                 tick_1us,
  output logic                 half_slot_p,
  output logic                 slot_p,
  output bb_pkg::bt_clock_u    clkn,
  output bb_pkg::bt_clock_u    clk
);

  localparam int US_W    = $clog2(`BB_CYC_PER_US);
  localparam int HSLOT_W = $clog2(`BB_CYC_PER_HSLOT);

  logic [US_W-1:0]    us_cnt;
  logic [HSLOT_W-1:0] hs_cnt;
  logic               us_wrap;
  logic               hs_wrap;
  bb_pkg::bt_clock_u  clkn_nxt;

  assign us_wrap = (us_cnt == US_W'(`BB_CYC_PER_US - 1));
  assign hs_wrap = (hs_cnt == HSLOT_W'(`BB_CYC_PER_HSLOT - 1));

  always_comb
  begin
    clkn_nxt.raw = clkn.raw + 1'b1;
    // slave runs on native clock plus offset, wraps at 2^28
    clk.raw      = is_master ? clkn.raw : clkn.raw + clk_offset;
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      us_cnt   <= '0;
      tick_1us <= 1'b0;
    end
    else
    begin
      tick_1us <= us_wrap;
      us_cnt   <= us_wrap ? '0 : us_cnt + 1'b1;
    end
  end

  // native clock, one count per half-slot
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      hs_cnt      <= '0;
      clkn        <= '0;
      half_slot_p <= 1'b0;
      slot_p      <= 1'b0;
    end
    else
    begin
      half_slot_p <= hs_wrap;
      // slot boundary when the new phase is even
      slot_p      <= hs_wrap & ~clkn_nxt.fld.phase[0];
      if (hs_wrap)
      begin
        hs_cnt <= '0;
        clkn   <= clkn_nxt;
      end
      else
        hs_cnt <= hs_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== design/bb_sync_correlator.sv ====
`default_nettype none

`include "bb_params.svh"

module bb_sync_correlator (
  input  logic                  clk_6M,
  input  logic                  rstz,
  input  logic                  rxbit,
  input  logic                  tick_1us,
  input  logic                  corr_en,
  input  logic [`BB_SYNC_W-1:0] expected_word,
  input  logic [`BB_CORR_W-1:0] corr_threshold,
  output logic                  sync_hit_p
);

  localparam int CORR_W = `BB_CORR_W;

  logic [1:0]            rx_meta;
  logic [`BB_SYNC_W-1:0] rx_window;
  logic [`BB_SYNC_W-1:0] agree;
  logic [CORR_W-1:0]     match_cnt;
  logic                  tick_d;

  // two-flop resync of the async receive bit
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      rx_meta <= 2'b00;
    else
      rx_meta <= {rx_meta[0], rxbit};
  end

  // sliding window, oldest bit ends up in the msb
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      rx_window <= '0;
    else if (tick_1us)
      rx_window <= {rx_window[`BB_SYNC_W-2:0], rx_meta[1]};
  end

  assign agree = rx_window ~^ expected_word;

  always_comb
  begin
    match_cnt = '0;
    for (int i = 0; i < `BB_SYNC_W; i++)
    begin
      match_cnt = match_cnt + CORR_W'(agree[i]);
    end
  end

  // count is valid the cycle after the shift
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      tick_d     <= 1'b0;
      sync_hit_p <= 1'b0;
    end
    else
    begin
      tick_d     <= tick_1us;
      sync_hit_p <= tick_d & corr_en & (match_cnt >= corr_threshold);
    end
  end

endmodule

`default_nettype wire

// ==== design/bb_link_ctrl.sv ====
`default_nettype none

`include "bb_params.svh"

module bb_link_ctrl (
  input  logic                  clk_6M,
  input  logic                  rstz,
  input  logic                  slot_p,
  input  logic                  page_scan_en_p,
  input  logic                  inquiry_scan_en_p,
  input  logic                  scan_cancel_p,
  input  logic                  detach_p,
  input  bb_pkg::scan_cfg_t     page_scan_cfg,
  input  bb_pkg::scan_cfg_t     inquiry_scan_cfg,
  input  bb_pkg::bd_addr_t      my_addr,
  input  bb_pkg::bd_addr_t      giac_addr,
  input  bb_pkg::bd_addr_t      master_addr,
  input  logic [`BB_SYNC_W-1:0] my_syncword,
  input  logic [`BB_SYNC_W-1:0] giac_syncword,
  input  logic [`BB_SYNC_W-1:0] master_syncword,
  input  logic                  sync_hit_p,
  output bb_pkg::link_state_e   link_state,
  output logic                  scan_window,
  output logic                  corr_en,
  output logic                  inquiry_hit_p,
  output logic [`BB_SYNC_W-1:0] expected_word,
  output bb_pkg::hop_addr_t     hop_addr
);

  bb_pkg::link_state_e   state_q;
  bb_pkg::link_state_e   state_d;
  bb_pkg::scan_cfg_t     cfg;
  bb_pkg::bd_addr_t      sel_addr;
  logic                  scanning;
  logic                  scan_armed;
  logic [`BB_SCAN_W-1:0] slot_cnt;
  logic [`BB_SCAN_W-1:0] slot_last;

  assign scanning  = (state_q == bb_pkg::page_scan) || (state_q == bb_pkg::inquiry_scan);
  assign cfg       = (state_q == bb_pkg::inquiry_scan) ? inquiry_scan_cfg : page_scan_cfg;
  // interval of zero behaves as one slot
  assign slot_last = (cfg.interval == '0) ? '0 : cfg.interval - 1'b1;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      bb_pkg::standby:
        if (page_scan_en_p)
          state_d = bb_pkg::page_scan;
        else if (inquiry_scan_en_p)
          state_d = bb_pkg::inquiry_scan;
      bb_pkg::page_scan:
        if (scan_cancel_p)
          state_d = bb_pkg::standby;
        else if (sync_hit_p)
          state_d = bb_pkg::connection;
      bb_pkg::inquiry_scan:
        if (scan_cancel_p)
          state_d = bb_pkg::standby;
      bb_pkg::connection:
        if (detach_p)
          state_d = bb_pkg::standby;
      default:
        state_d = bb_pkg::standby;
    endcase
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      state_q       <= bb_pkg::standby;
      inquiry_hit_p <= 1'b0;
    end
    else
    begin
      state_q       <= state_d;
      inquiry_hit_p <= (state_q == bb_pkg::inquiry_scan) & sync_hit_p;
    end
  end

  // slot counter, first slot_p after entry marks slot zero
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      scan_armed <= 1'b0;
      slot_cnt   <= '0;
    end
    else if (!scanning)
    begin
      scan_armed <= 1'b0;
      slot_cnt   <= '0;
    end
    else if (slot_p)
    begin
      scan_armed <= 1'b1;
      if (!scan_armed || slot_cnt >= slot_last)
        slot_cnt <= '0;
      else
        slot_cnt <= slot_cnt + 1'b1;
    end
  end

  assign scan_window = scanning & scan_armed & (slot_cnt < cfg.window);
  assign corr_en     = scan_window | (state_q == bb_pkg::connection);
  assign link_state  = state_q;

  // sync word and hop address follow the state
  always_comb
  begin
    case (state_q)
      bb_pkg::page_scan:
      begin
        expected_word = my_syncword;
        sel_addr      = my_addr;
      end
      bb_pkg::inquiry_scan:
      begin
        expected_word = giac_syncword;
        sel_addr      = giac_addr;
      end
      default:
      begin
        expected_word = master_syncword;
        sel_addr      = master_addr;
      end
    endcase
  end

  assign hop_addr = {sel_addr.uap[3:0], sel_addr.lap};

endmodule

`default_nettype wire

// ==== design/bb_top.sv ====
`default_nettype none

`include "bb_params.svh"

module bb_top (
  input  logic                  clk_6M,
  input  logic                  rstz,
  input  logic                  rxbit,
  input  logic                  is_master,
  input  logic [`BB_CLK_W-1:0]  clk_offset,
  input  bb_pkg::bd_addr_t      my_addr,
  input  bb_pkg::bd_addr_t      giac_addr,
  input  bb_pkg::bd_addr_t      master_addr,
  input  logic [`BB_SYNC_W-1:0] my_syncword,
  input  logic [`BB_SYNC_W-1:0] giac_syncword,
  input  logic [`BB_SYNC_W-1:0] master_syncword,
  input  bb_pkg::scan_cfg_t     page_scan_cfg,
  input  bb_pkg::scan_cfg_t     inquiry_scan_cfg,
  input  logic [`BB_CORR_W-1:0] corr_threshold,
  input  logic                  page_scan_en_p,
  input  logic                  inquiry_scan_en_p,
  input  logic                  scan_cancel_p,
  input  logic                  detach_p,
  output bb_pkg::bt_clock_u     clkn,
  output bb_pkg::bt_clock_u     clk,
  output logic                  half_slot_p,
  output bb_pkg::link_state_e   link_state,
  output logic                  scan_window,
  output logic                  sync_hit_p,
  output logic                  inquiry_hit_p,
  output bb_pkg::hop_addr_t     hop_addr
);

  logic                  tick_1us;
  logic                  slot_p;
  logic                  corr_en;
  logic [`BB_SYNC_W-1:0] expected_word;

  bb_timebase u_timebase (
    .clk_6M      (clk_6M),
    .rstz        (rstz),
    .is_master   (is_master),
    .clk_offset  (clk_offset),
    .tick_1us    (tick_1us),
    .half_slot_p (half_slot_p),
    .slot_p      (slot_p),
    .clkn        (clkn),
    .clk         (clk)
  );

  bb_sync_correlator u_correlator (
    .clk_6M         (clk_6M),
    .rstz           (rstz),
    .rxbit          (rxbit),
    .tick_1us       (tick_1us),
    .corr_en        (corr_en),
    .expected_word  (expected_word),
    .corr_threshold (corr_threshold),
    .sync_hit_p     (sync_hit_p)
  );

  bb_link_ctrl u_link_ctrl (
    .clk_6M            (clk_6M),
    .rstz              (rstz),
    .slot_p            (slot_p),
    .page_scan_en_p    (page_scan_en_p),
    .inquiry_scan_en_p (inquiry_scan_en_p),
    .scan_cancel_p     (scan_cancel_p),
    .detach_p          (detach_p),
    .page_scan_cfg     (page_scan_cfg),
    .inquiry_scan_cfg  (inquiry_scan_cfg),
    .my_addr           (my_addr),
    .giac_addr         (giac_addr),
    .master_addr       (master_addr),
    .my_syncword       (my_syncword),
    .giac_syncword     (giac_syncword),
    .master_syncword   (master_syncword),
    .sync_hit_p        (sync_hit_p),
    .link_state        (link_state),
    .scan_window       (scan_window),
    .corr_en           (corr_en),
    .inquiry_hit_p     (inquiry_hit_p),
    .expected_word     (expected_word),
    .hop_addr          (hop_addr)
  );

endmodule

`default_nettype wire

// ==== verif/bb_assert.sv ====
`default_nettype none

module bb_assert (
  input  logic                clk_6M,
  input  logic                rstz,
  input  bb_pkg::bt_clock_u   clkn,
  input  logic                half_slot_p,
  input  bb_pkg::link_state_e link_state,
  input  logic                sync_hit_p,
  input  logic                scan_window
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_cnt = 0;

  a_clkn_step: assert property (@(posedge clk_6M) disable iff (!rstz)
    (clkn.raw != $past(clkn.raw)) |-> half_slot_p)
  else
  begin
    $error("clkn changed outside a half-slot boundary");
    fail_cnt++;
  end

  a_no_hit_standby: assert property (@(posedge clk_6M) disable iff (!rstz)
    sync_hit_p |-> (link_state != bb_pkg::standby))
  else
  begin
    $error("sync hit seen in standby");
    fail_cnt++;
  end

  // connection is only reachable from page scan
  a_conn_entry: assert property (@(posedge clk_6M) disable iff (!rstz)
    (link_state == bb_pkg::connection) |->
      ($past(link_state) inside {bb_pkg::page_scan, bb_pkg::connection}))
  else
  begin
    $error("connection entered from a state other than page scan");
    fail_cnt++;
  end

  a_window_idle: assert property (@(posedge clk_6M) disable iff (!rstz)
    (link_state == bb_pkg::standby || link_state == bb_pkg::connection) |-> !scan_window)
  else
  begin
    $error("scan window open outside the scan states");
    fail_cnt++;
  end

endmodule

bind bb_top bb_assert u_assert (
  .clk_6M      (clk_6M),
  .rstz        (rstz),
  .clkn        (clkn),
  .half_slot_p (half_slot_p),
  .link_state  (link_state),
  .sync_hit_p  (sync_hit_p),
  .scan_window (scan_window)
);

`default_nettype wire

// ==== verif/bb_tb.sv ====
`default_nettype none

`include "bb_params.svh"

module bb_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned MAX_CYCLES = 200_000;

  logic                  clk_6M = 1'b0;
  logic                  rstz;
  logic                  rxbit;
  logic                  is_master;
  logic [`BB_CLK_W-1:0]  clk_offset;
  bb_pkg::bd_addr_t      my_addr;
  bb_pkg::bd_addr_t      giac_addr;
  bb_pkg::bd_addr_t      master_addr;
  logic [`BB_SYNC_W-1:0] my_syncword;
  logic [`BB_SYNC_W-1:0] giac_syncword;
  logic [`BB_SYNC_W-1:0] master_syncword;
  bb_pkg::scan_cfg_t     page_scan_cfg;
  bb_pkg::scan_cfg_t     inquiry_scan_cfg;
  logic [`BB_CORR_W-1:0] corr_threshold;
  logic                  page_scan_en_p;
  logic                  inquiry_scan_en_p;
  logic                  scan_cancel_p;
  logic                  detach_p;
  bb_pkg::bt_clock_u     clkn;
  bb_pkg::bt_clock_u     clk;
  logic                  half_slot_p;
  bb_pkg::link_state_e   link_state;
  logic                  scan_window;
  logic                  sync_hit_p;
  logic                  inquiry_hit_p;
  bb_pkg::hop_addr_t     hop_addr;

  int unsigned err_cnt = 0;
  int unsigned cyc_cnt = 0;
  int unsigned rel_cnt = 0;
  int unsigned hit_cnt = 0;
  int unsigned inq_cnt = 0;
  logic [31:0] lcg_state = 32'd41;

  bb_top u_dut (.*);

  always #5 clk_6M = ~clk_6M;

  always @(posedge clk_6M)
  begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt >= MAX_CYCLES)
    begin
      $display("run stopped, no progress after %0d cycles", cyc_cnt);
      $display("TEST FAIL");
      $finish;
    end
  end

  // cycle count since reset release sets the 1 us tick phase
  always @(posedge clk_6M)
  begin
    if (!rstz)
      rel_cnt <= 0;
    else
      rel_cnt <= rel_cnt + 1;
  end

  always @(negedge clk_6M)
  begin
    if (sync_hit_p)
      hit_cnt <= hit_cnt + 1;
    if (inquiry_hit_p)
      inq_cnt <= inq_cnt + 1;
  end

  function automatic logic [63:0] rand_word();
    logic [63:0] w;
    lcg_state  = lcg_state * 32'd1664525 + 32'd1013904223;
    w[63:32]   = lcg_state;
    lcg_state  = lcg_state * 32'd1664525 + 32'd1013904223;
    w[31:0]    = lcg_state;
    return w;
  endfunction

  task automatic expect_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act)
    begin
      err_cnt++;
      $display("FAILED %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  task automatic wait_half_slot(output int unsigned n);
    n = 0;
    do
    begin
      @(negedge clk_6M);
      n++;
    end
    while (!half_slot_p && n < 4000);
    if (!half_slot_p)
    begin
      err_cnt++;
      $display("half_slot_p did not pulse within %0d cycles", n);
    end
  endtask

  task automatic wait_window(input logic level);
    int unsigned guard;
    guard = 0;
    while (scan_window !== level && guard < 8000)
    begin
      @(negedge clk_6M);
      guard++;
    end
    if (scan_window !== level)
    begin
      err_cnt++;
      $display("scan_window never reached %b", level);
    end
  endtask

  // half-slot pulses seen while scan_window stays at level
  task automatic count_half_slots(input logic level, output int unsigned cnt);
    int unsigned guard;
    cnt   = 0;
    guard = 0;
    while (scan_window === level && guard < 20000)
    begin
      if (half_slot_p)
        cnt++;
      @(negedge clk_6M);
      guard++;
    end
  endtask

  // sends msb first and moves rxbit mid-period between sampling edges
  task automatic stream_word(input logic [63:0] word);
    for (int i = 63; i >= 0; i--)
    begin
      do
        @(posedge clk_6M);
      while ((rel_cnt % 6) != 1);
      rxbit <= word[i];
    end
    repeat (12) @(negedge clk_6M);
  endtask

  task automatic test_reset_clock();
    int unsigned n;
    expect_eq("reset link_state", bb_pkg::standby, link_state);
    expect_eq("reset scan_window", 1'b0, scan_window);
    wait_half_slot(n);
    expect_eq("first half-slot", 1875, n);
    expect_eq("clkn after one half-slot", 1, clkn.raw);
    wait_half_slot(n);
    expect_eq("half-slot period", 1875, n);
    expect_eq("clkn after two half-slots", 2, clkn.raw);
    // offset chosen so the slave clock wraps
    expect_eq("slave clk", `BB_CLK_W'(2 + clk_offset), clk.raw);
    @(posedge clk_6M);
    is_master <= 1'b1;
    @(negedge clk_6M);
    expect_eq("master clk", 2, clk.raw);
    @(posedge clk_6M);
    is_master <= 1'b0;
    @(negedge clk_6M);
  endtask

  task automatic test_page_window();
    int unsigned hs_on;
    int unsigned hs_off;
    @(posedge clk_6M);
    page_scan_en_p <= 1'b1;
    @(posedge clk_6M);
    page_scan_en_p <= 1'b0;
    @(negedge clk_6M);
    expect_eq("page scan entry", bb_pkg::page_scan, link_state);
    // low uap nibble above the lap
    expect_eq("page scan hop_addr", 28'hA3C_71E2, hop_addr);
    wait_window(1'b1);
    count_half_slots(1'b1, hs_on);
    count_half_slots(1'b0, hs_off);
    expect_eq("window open half-slots", 4, hs_on);
    expect_eq("window closed half-slots", 4, hs_off);
  endtask

  task automatic test_page_hit();
    stream_word(my_syncword);
    expect_eq("page hit state", bb_pkg::connection, link_state);
    expect_eq("connection hop_addr", 28'h712_A4F0, hop_addr);
  endtask

  task automatic test_threshold();
    logic [63:0] flipped;
    int unsigned h0;
    flipped = master_syncword ^ 64'h8000_0100_0000_0001;
    @(posedge clk_6M);
    corr_threshold <= 7'd61;
    h0 = hit_cnt;
    stream_word(flipped);
    expect_eq("3 flips, threshold 61", h0 + 1, hit_cnt);
    @(posedge clk_6M);
    corr_threshold <= 7'd62;
    h0 = hit_cnt;
    stream_word(flipped);
    expect_eq("3 flips, threshold 62", h0, hit_cnt);
    @(posedge clk_6M);
    corr_threshold <= 7'd64;
    h0 = hit_cnt;
    stream_word(rand_word());
    expect_eq("random word, threshold 64", h0, hit_cnt);
  endtask

  task automatic test_detach();
    @(posedge clk_6M);
    detach_p <= 1'b1;
    @(posedge clk_6M);
    detach_p <= 1'b0;
    @(negedge clk_6M);
    expect_eq("detach state", bb_pkg::standby, link_state);
  endtask

  task automatic test_inquiry();
    int unsigned h0;
    int unsigned i0;
    @(posedge clk_6M);
    inquiry_scan_en_p <= 1'b1;
    @(posedge clk_6M);
    inquiry_scan_en_p <= 1'b0;
    @(negedge clk_6M);
    expect_eq("inquiry scan entry", bb_pkg::inquiry_scan, link_state);
    expect_eq("inquiry hop_addr", 28'h09E_8B33, hop_addr);
    wait_window(1'b1);
    h0 = hit_cnt;
    i0 = inq_cnt;
    stream_word(giac_syncword);
    expect_eq("inquiry sync hits", h0 + 1, hit_cnt);
    expect_eq("inquiry_hit_p pulses", i0 + 1, inq_cnt);
    expect_eq("state after inquiry hit", bb_pkg::inquiry_scan, link_state);
    @(posedge clk_6M);
    scan_cancel_p <= 1'b1;
    @(posedge clk_6M);
    scan_cancel_p <= 1'b0;
    @(negedge clk_6M);
    expect_eq("cancel state", bb_pkg::standby, link_state);
    h0 = hit_cnt;
    stream_word(giac_syncword);
    // standby still selects the master word, so only a closed correlator stops this
    stream_word(master_syncword);
    expect_eq("hits in standby", h0, hit_cnt);
  endtask

  initial
  begin
    rstz              = 1'b0;
    rxbit             = 1'b0;
    is_master         = 1'b0;
    clk_offset        = 28'hFFF_FFFE;
    my_addr           = '{uap: 8'h5A, lap: 24'h3C_71E2};
    giac_addr         = '{uap: 8'h00, lap: 24'h9E_8B33};
    master_addr       = '{uap: 8'hC7, lap: 24'h12_A4F0};
    my_syncword       = rand_word();
    giac_syncword     = rand_word();
    master_syncword   = rand_word();
    page_scan_cfg     = '{interval: 16'd4, window: 16'd2};
    inquiry_scan_cfg  = '{interval: 16'd1, window: 16'd1};
    corr_threshold    = 7'd64;
    page_scan_en_p    = 1'b0;
    inquiry_scan_en_p = 1'b0;
    scan_cancel_p     = 1'b0;
    detach_p          = 1'b0;
    repeat (4) @(posedge clk_6M);
    rstz <= 1'b1;
    @(negedge clk_6M);
    test_reset_clock();
    test_page_window();
    test_page_hit();
    test_threshold();
    test_detach();
    test_inquiry();
    $display("errors: checks %0d, assertions %0d", err_cnt, u_dut.u_assert.fail_cnt);
    if (err_cnt == 0 && u_dut.u_assert.fail_cnt == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+design
design/bb_pkg.sv
design/bb_timebase.sv
design/bb_sync_correlator.sv
design/bb_link_ctrl.sv
design/bb_top.sv
verif/bb_assert.sv
verif/bb_tb.sv

// ==== Bender.yml ====
package:
  name: bb_baseband_rx

sources:
  - include_dirs:
      - design
    files:
      - design/bb_pkg.sv
      - design/bb_timebase.sv
      - design/bb_sync_correlator.sv
      - design/bb_link_ctrl.sv
      - design/bb_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - verif/bb_assert.sv
      - verif/bb_tb.sv
